/* common/mdu_defs.svh */
`ifndef MDU_DEFS_SVH
`define MDU_DEFS_SVH

// Data word of the integer pipe.
`define MDU_WORD_W 32

// Physical register number.
`define MDU_PRF_W 6

// Reorder-buffer tag.
`define MDU_ROB_W 5

// Product stages after the operand register, 2 to 5.
`define MDU_MUL_CYCLE 3

`endif

/* common/mduPkg.sv */
`include "mdu_defs.svh"

package mduPkg;

    typedef enum logic [1:0] {
        opMult  = 2'd0,
        opMultu = 2'd1,
        opDiv   = 2'd2,
        opDivu  = 2'd3
    } mduOp;

    typedef logic [`MDU_PRF_W-1:0] prfNum;

    typedef logic [`MDU_ROB_W-1:0] robId;

    // The multiplier writes prod, the divider writes divide.
    // Writeback only looks at halves.
    typedef union packed {
        logic [2*`MDU_WORD_W-1:0] prod;

        struct packed {
            logic [`MDU_WORD_W-1:0] rem;   // Goes to HI.
            logic [`MDU_WORD_W-1:0] quo;   // Goes to LO.
        } divide;

        struct packed {
            logic [`MDU_WORD_W-1:0] hi;
            logic [`MDU_WORD_W-1:0] lo;
        } halves;
    } mduResult;

endpackage

/* mdu/mulPipe.sv */
`include "mdu_defs.svh"

module mulPipe (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   mulStart,
    input  logic                   isSigned,
    input  logic [`MDU_WORD_W-1:0] srcA,
    input  logic [`MDU_WORD_W-1:0] srcB,
    input  mduPkg::prfNum          dstHi,
    input  mduPkg::prfNum          dstLo,
    input  mduPkg::robId           robHi,
    input  mduPkg::robId           robLo,
    output logic                   mulDone,
    output mduPkg::mduResult       mulRes,
    output mduPkg::prfNum          mulDstHi,
    output mduPkg::prfNum          mulDstLo,
    output mduPkg::robId           mulRobHi,
    output mduPkg::robId           mulRobLo
);
    localparam int W = `MDU_WORD_W;
    localparam int Stages = `MDU_MUL_CYCLE;

    logic                  opValid;
    logic signed [W:0]     opA;
    logic signed [W:0]     opB;
    mduPkg::prfNum         opDstHi;
    mduPkg::prfNum         opDstLo;
    mduPkg::robId          opRobHi;
    mduPkg::robId          opRobLo;
    logic signed [2*W+1:0] fullProd;

    logic [Stages-1:0]     pipeValid;
    mduPkg::mduResult      pipeRes   [Stages];
    mduPkg::prfNum         pipeDstHi [Stages];
    mduPkg::prfNum         pipeDstLo [Stages];
    mduPkg::robId          pipeRobHi [Stages];
    mduPkg::robId          pipeRobLo [Stages];

    always_ff @(posedge clk) begin
        if (rst) begin
            opValid   <= 1'b0;
            pipeValid <= '0;
        end else begin
            opValid   <= mulStart;
            pipeValid <= {pipeValid[Stages-2:0], opValid};
        end
    end

    // 33-bit operands let one signed multiplier serve MULT and MULTU.
    always_ff @(posedge clk) begin
        if (mulStart) begin
            opA     <= {isSigned & srcA[W-1], srcA};
            opB     <= {isSigned & srcB[W-1], srcB};
            opDstHi <= dstHi;
            opDstLo <= dstLo;
            opRobHi <= robHi;
            opRobLo <= robLo;
        end
    end

    assign fullProd = opA * opB;

    always_ff @(posedge clk) begin
        pipeRes[0].prod <= fullProd[2*W-1:0];
        pipeDstHi[0]    <= opDstHi;
        pipeDstLo[0]    <= opDstLo;
        pipeRobHi[0]    <= opRobHi;
        pipeRobLo[0]    <= opRobLo;
        for (int i = 1; i < Stages; i++) begin
            pipeRes[i]   <= pipeRes[i-1];
            pipeDstHi[i] <= pipeDstHi[i-1];
            pipeDstLo[i] <= pipeDstLo[i-1];
            pipeRobHi[i] <= pipeRobHi[i-1];
            pipeRobLo[i] <= pipeRobLo[i-1];
        end
    end

    assign mulDone  = pipeValid[Stages-1];
    assign mulRes   = pipeRes[Stages-1];
    assign mulDstHi = pipeDstHi[Stages-1];
    assign mulDstLo = pipeDstLo[Stages-1];
    assign mulRobHi = pipeRobHi[Stages-1];
    assign mulRobLo = pipeRobLo[Stages-1];

    // Writeback drains one result per two cycles.
    assert property (@(posedge clk) disable iff (rst) mulStart |=> !mulStart)
        else $error("mulPipe: multiplies issued on consecutive cycles");

endmodule

/* mdu/divUnit.sv */
`include "mdu_defs.svh"

module divUnit (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   divStart,
    input  logic                   isSigned,
    input  logic [`MDU_WORD_W-1:0] srcA,
    input  logic [`MDU_WORD_W-1:0] srcB,
    input  mduPkg::prfNum          dstHi,
    input  mduPkg::prfNum          dstLo,
    input  mduPkg::robId           robHi,
    input  mduPkg::robId           robLo,
    input  logic                   divTaken,
    output logic                   divBusy,
    output logic                   divDone,
    output mduPkg::mduResult       divRes,
    output mduPkg::prfNum          divDstHi,
    output mduPkg::prfNum          divDstLo,
    output mduPkg::robId           divRobHi,
    output mduPkg::robId           divRobLo
);
    localparam int W = `MDU_WORD_W;
    localparam int CntW = $clog2(W) + 1;

    logic [CntW-1:0] stepCnt;
    logic [W-1:0]    absA;
    logic [W-1:0]    absB;
    logic [W-1:0]    dvsr;
    logic [W-1:0]    remReg;
    logic [W-1:0]    quoReg;      // Dividend bits shift out, quotient bits shift in.
    logic [W-1:0]    remNext;
    logic [W-1:0]    quoNext;
    logic [W:0]      partial;
    logic [W:0]      diff;
    logic            fits;
    logic            negQ;
    logic            negR;
    logic            zeroDiv;

    assign absA = (isSigned && srcA[W-1]) ? -srcA : srcA;
    assign absB = (isSigned && srcB[W-1]) ? -srcB : srcB;

    // One restoring step.
    assign partial = {remReg, quoReg[W-1]};
    assign diff    = partial - {1'b0, dvsr};
    assign fits    = partial >= {1'b0, dvsr};
    assign remNext = fits ? diff[W-1:0] : partial[W-1:0];
    assign quoNext = {quoReg[W-2:0], fits};

    always_ff @(posedge clk) begin
        if (rst) begin
            divBusy <= 1'b0;
            divDone <= 1'b0;
            stepCnt <= '0;
        end else begin
            divDone <= (stepCnt == CntW'(1));
            if (divStart) begin
                divBusy <= 1'b1;
                stepCnt <= CntW'(W);
            end else if (stepCnt != '0) begin
                stepCnt <= stepCnt - 1'b1;
            end
            // Result stays here until writeback has copied it.
            if (divTaken) begin
                divBusy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (divStart) begin
            dvsr     <= absB;
            quoReg   <= absA;
            remReg   <= '0;
            negQ     <= isSigned & (srcA[W-1] ^ srcB[W-1]);
            negR     <= isSigned & srcA[W-1];     // Remainder follows the dividend.
            zeroDiv  <= (srcB == '0);
            divDstHi <= dstHi;
            divDstLo <= dstLo;
            divRobHi <= robHi;
            divRobLo <= robLo;
        end else if (stepCnt != '0) begin
            remReg <= remNext;
            quoReg <= quoNext;
        end

        // Last step also fixes the signs.
        // MIN / -1 needs nothing extra, magnitude 2^31 negates to itself.
        if (stepCnt == CntW'(1)) begin
            divRes.divide.quo <= zeroDiv ? '1 : (negQ ? -quoNext : quoNext);
            divRes.divide.rem <= negR ? -remNext : remNext;   // Dividend when divisor is 0.
        end
    end

    assert property (@(posedge clk) disable iff (rst) divStart |-> !divBusy)
        else $error("divUnit: divide issued while divider busy");

endmodule

/* mdu/mduWriteback.sv */
`include "mdu_defs.svh"

module mduWriteback (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   mulDone,
    input  mduPkg::mduResult       mulRes,
    input  mduPkg::prfNum          mulDstHi,
    input  mduPkg::prfNum          mulDstLo,
    input  mduPkg::robId           mulRobHi,
    input  mduPkg::robId           mulRobLo,
    input  logic                   divDone,
    input  mduPkg::mduResult       divRes,
    input  mduPkg::prfNum          divDstHi,
    input  mduPkg::prfNum          divDstLo,
    input  mduPkg::robId           divRobHi,
    input  mduPkg::robId           divRobLo,
    output logic                   divTaken,
    output logic                   wbEn,
    output mduPkg::prfNum          wbDst,
    output logic [`MDU_WORD_W-1:0] wbData,
    output mduPkg::robId           wbRob
);
    typedef enum logic [1:0] {
        idle,
        hiOut,
        loOut,
        loHold     // Lo cycle with a multiply parked behind it.
    } wbState;

    wbState           state;
    wbState           nextState;
    logic             divPending;
    logic             slotFree;
    logic             takeMul;
    logic             parkMul;
    logic             grantDiv;

    mduPkg::mduResult curRes;
    mduPkg::prfNum    curDstHi;
    mduPkg::prfNum    curDstLo;
    mduPkg::robId     curRobHi;
    mduPkg::robId     curRobLo;
    mduPkg::mduResult parkRes;
    mduPkg::prfNum    parkDstHi;
    mduPkg::prfNum    parkDstLo;
    mduPkg::robId     parkRobHi;
    mduPkg::robId     parkRobLo;

    assign slotFree = (state == idle) || (state == loOut);
    assign takeMul  = mulDone && slotFree;
    assign parkMul  = mulDone && (state == hiOut);   // Result can't wait in mulPipe.
    assign grantDiv = divPending && !mulDone && slotFree;
    assign divTaken = grantDiv;

    always_comb begin
        case (state)
            idle, loOut: nextState = (mulDone || grantDiv) ? hiOut : idle;
            hiOut:       nextState = parkMul ? loHold : loOut;
            loHold:      nextState = hiOut;
            default:     nextState = idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= idle;
            divPending <= 1'b0;
        end else begin
            state <= nextState;
            if (divDone) begin
                divPending <= 1'b1;
            end else if (grantDiv) begin
                divPending <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (takeMul) begin
            curRes   <= mulRes;
            curDstHi <= mulDstHi;
            curDstLo <= mulDstLo;
            curRobHi <= mulRobHi;
            curRobLo <= mulRobLo;
        end else if (grantDiv) begin
            curRes   <= divRes;
            curDstHi <= divDstHi;
            curDstLo <= divDstLo;
            curRobHi <= divRobHi;
            curRobLo <= divRobLo;
        end else if (state == loHold) begin
            curRes   <= parkRes;
            curDstHi <= parkDstHi;
            curDstLo <= parkDstLo;
            curRobHi <= parkRobHi;
            curRobLo <= parkRobLo;
        end

        if (parkMul) begin
            parkRes   <= mulRes;
            parkDstHi <= mulDstHi;
            parkDstLo <= mulDstLo;
            parkRobHi <= mulRobHi;
            parkRobLo <= mulRobLo;
        end
    end

    assign wbEn   = (state != idle);
    assign wbDst  = (state == hiOut) ? curDstHi : curDstLo;
    assign wbData = (state == hiOut) ? curRes.halves.hi : curRes.halves.lo;
    assign wbRob  = (state == hiOut) ? curRobHi : curRobLo;

    // A park leaves no room for a second one in the next cycle.
    // Issue spacing keeps mulDone apart by two cycles.
    assert property (@(posedge clk) disable iff (rst) state == loHold |-> !mulDone)
        else $error("mduWriteback: multiply result arrived while one is parked");

endmodule

/* mdu/mduTop.sv */
`include "mdu_defs.svh"

module mduTop (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   issueValid,
    input  mduPkg::mduOp           issueOp,
    input  logic [`MDU_WORD_W-1:0] srcA,
    input  logic [`MDU_WORD_W-1:0] srcB,
    input  mduPkg::prfNum          dstHi,
    input  mduPkg::prfNum          dstLo,
    input  mduPkg::robId           robHi,
    input  mduPkg::robId           robLo,
    output logic                   divBusy,
    output logic                   wbEn,
    output mduPkg::prfNum          wbDst,
    output logic [`MDU_WORD_W-1:0] wbData,
    output mduPkg::robId           wbRob
);
    logic             isMul;
    logic             isSigned;
    logic             mulStart;
    logic             divStart;
    logic             divTaken;

    logic             mulDone;
    mduPkg::mduResult mulRes;
    mduPkg::prfNum    mulDstHi;
    mduPkg::prfNum    mulDstLo;
    mduPkg::robId     mulRobHi;
    mduPkg::robId     mulRobLo;

    logic             divDone;
    mduPkg::mduResult divRes;
    mduPkg::prfNum    divDstHi;
    mduPkg::prfNum    divDstLo;
    mduPkg::robId     divRobHi;
    mduPkg::robId     divRobLo;

    // The only place the opcode is decoded.
    assign isMul    = (issueOp == mduPkg::opMult) || (issueOp == mduPkg::opMultu);
    assign isSigned = (issueOp == mduPkg::opMult) || (issueOp == mduPkg::opDiv);
    assign mulStart = issueValid && isMul;
    assign divStart = issueValid && !isMul;

    mulPipe uMul (
        .clk      (clk),
        .rst      (rst),
        .mulStart (mulStart),
        .isSigned (isSigned),
        .srcA     (srcA),
        .srcB     (srcB),
        .dstHi    (dstHi),
        .dstLo    (dstLo),
        .robHi    (robHi),
        .robLo    (robLo),
        .mulDone  (mulDone),
        .mulRes   (mulRes),
        .mulDstHi (mulDstHi),
        .mulDstLo (mulDstLo),
        .mulRobHi (mulRobHi),
        .mulRobLo (mulRobLo)
    );

    divUnit uDiv (
        .clk      (clk),
        .rst      (rst),
        .divStart (divStart),
        .isSigned (isSigned),
        .srcA     (srcA),
        .srcB     (srcB),
        .dstHi    (dstHi),
        .dstLo    (dstLo),
        .robHi    (robHi),
        .robLo    (robLo),
        .divTaken (divTaken),
        .divBusy  (divBusy),
        .divDone  (divDone),
        .divRes   (divRes),
        .divDstHi (divDstHi),
        .divDstLo (divDstLo),
        .divRobHi (divRobHi),
        .divRobLo (divRobLo)
    );

    mduWriteback uWb (
        .clk      (clk),
        .rst      (rst),
        .mulDone  (mulDone),
        .mulRes   (mulRes),
        .mulDstHi (mulDstHi),
        .mulDstLo (mulDstLo),
        .mulRobHi (mulRobHi),
        .mulRobLo (mulRobLo),
        .divDone  (divDone),
        .divRes   (divRes),
        .divDstHi (divDstHi),
        .divDstLo (divDstLo),
        .divRobHi (divRobHi),
        .divRobLo (divRobLo),
        .divTaken (divTaken),
        .wbEn     (wbEn),
        .wbDst    (wbDst),
        .wbData   (wbData),
        .wbRob    (wbRob)
    );

endmodule

/* dv/tbClock.sv */
module tbClock (
    output logic clk,
    output logic rst
);
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clk);
        #1 rst = 1'b0;   // Released just after the second edge.
    end
endmodule

/* dv/mduTb.sv */
`include "mdu_defs.svh"

module mduTb;
    localparam int W = `MDU_WORD_W;
    localparam int NumRegs = 2 ** `MDU_PRF_W;
    localparam int NumFixed = 21;
    localparam int NumEntries = 30;
    localparam int TimeoutCycles = NumEntries * 40 + 20;
    localparam mduPkg::prfNum TimedDst = '0;   // Hi destination of entry 0.

    typedef struct packed {
        mduPkg::mduOp op;
        logic [W-1:0] a;
        logic [W-1:0] b;
        logic [7:0]   gap;   // Idle cycles after the issue cycle.
    } stimEntry;

    logic             clk;
    logic             rst;
    logic             issueValid;
    mduPkg::mduOp     issueOp;
    logic [W-1:0]     srcA;
    logic [W-1:0]     srcB;
    mduPkg::prfNum    dstHi;
    mduPkg::prfNum    dstLo;
    mduPkg::robId     robHi;
    mduPkg::robId     robLo;
    logic             divBusy;
    logic             wbEn;
    mduPkg::prfNum    wbDst;
    logic [W-1:0]     wbData;
    mduPkg::robId     wbRob;

    stimEntry         stim [NumEntries];
    logic [31:0]      lcgState = 32'hc413;
    int               cycleCount = 0;
    int               writtenCount = 0;
    int               timedIssue = 0;

    // Expected writes, indexed by destination register.
    logic [W-1:0]     expWord   [NumRegs];
    mduPkg::robId     expRob    [NumRegs];
    mduPkg::prfNum    expPair   [NumRegs];
    logic             expIsHi   [NumRegs];
    logic             expIssued [NumRegs];
    logic             expDone   [NumRegs];
    logic             prevHi = 1'b0;
    mduPkg::prfNum    prevDst = '0;

    tbClock uClock (
        .clk (clk),
        .rst (rst)
    );

    mduTop dut (
        .clk        (clk),
        .rst        (rst),
        .issueValid (issueValid),
        .issueOp    (issueOp),
        .srcA       (srcA),
        .srcB       (srcB),
        .dstHi      (dstHi),
        .dstLo      (dstLo),
        .robHi      (robHi),
        .robLo      (robLo),
        .divBusy    (divBusy),
        .wbEn       (wbEn),
        .wbDst      (wbDst),
        .wbData     (wbData),
        .wbRob      (wbRob)
    );

    function automatic logic [31:0] nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    // Returns {hi, lo} as the architecture defines them.
    function automatic logic [2*W-1:0] expectedResult(mduPkg::mduOp op, logic [W-1:0] a,
                                                      logic [W-1:0] b);
        longint      pa;
        longint      pb;
        int          sa;
        int          sb;
        logic [W-1:0] q;
        logic [W-1:0] r;
        pa = $signed(a);
        pb = $signed(b);
        sa = a;
        sb = b;
        case (op)
            mduPkg::opMultu: return {{W{1'b0}}, a} * {{W{1'b0}}, b};
            mduPkg::opMult:  return pa * pb;
            mduPkg::opDivu: begin
                if (b == '0) return {a, {W{1'b1}}};
                return {a % b, a / b};
            end
            default: begin
                if (b == '0) return {a, {W{1'b1}}};
                if (a == {1'b1, {(W-1){1'b0}}} && b == '1) return {{W{1'b0}}, a};
                q = sa / sb;   // Truncates toward zero.
                r = sa % sb;   // Sign of the dividend.
                return {r, q};
            end
        endcase
    endfunction

    task automatic failNow(string why);
        $display("%s", why);
        $display("tests failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic checkBit(string name, logic got, logic exp);
        if (got !== exp)
            failNow($sformatf("mismatch at %0t: %s got %b expected %b", $time, name, got, exp));
    endtask

    task automatic checkDst(string name, mduPkg::prfNum got, mduPkg::prfNum exp);
        if (got !== exp)
            failNow($sformatf("mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp));
    endtask

    task automatic checkWord(string name, logic [W-1:0] got, logic [W-1:0] exp);
        if (got !== exp)
            failNow($sformatf("mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
    endtask

    task automatic checkRob(string name, mduPkg::robId got, mduPkg::robId exp);
        if (got !== exp)
            failNow($sformatf("mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp));
    endtask

    task automatic checkLatency(string name, int got, int exp);
        if (got != exp)
            failNow($sformatf("mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp));
    endtask

    task automatic loadTable();
        logic [31:0] r;
        stim[0]  = '{mduPkg::opMultu, 32'h0000_1234, 32'h0000_5678, 8'd8};
        stim[1]  = '{mduPkg::opMultu, 32'hffff_ffff, 32'hffff_ffff, 8'd1};
        stim[2]  = '{mduPkg::opMult,  32'hffff_ffff, 32'hffff_ffff, 8'd1};
        stim[3]  = '{mduPkg::opMult,  32'h8000_0000, 32'h7fff_ffff, 8'd1};
        stim[4]  = '{mduPkg::opMult,  32'hffff_fff9, 32'h0000_0003, 8'd2};
        stim[5]  = '{mduPkg::opDivu,  32'hffff_fff0, 32'h0000_0007, 8'd1};
        stim[6]  = '{mduPkg::opDiv,   32'hffff_fff9, 32'h0000_0002, 8'd1};
        stim[7]  = '{mduPkg::opDiv,   32'h0000_0007, 32'hffff_fffe, 8'd1};
        stim[8]  = '{mduPkg::opDiv,   32'hffff_fff9, 32'hffff_fffe, 8'd1};
        stim[9]  = '{mduPkg::opDiv,   32'h8000_0000, 32'hffff_ffff, 8'd1};
        stim[10] = '{mduPkg::opDivu,  32'h1234_5678, 32'h0000_0000, 8'd1};
        stim[11] = '{mduPkg::opDiv,   32'hffff_fff9, 32'h0000_0000, 8'd1};
        // Divide finishes in the middle of the multiply burst below.
        stim[12] = '{mduPkg::opDiv,   32'h0000_0064, 32'h0000_0007, 8'd26};
        stim[13] = '{mduPkg::opMult,  32'h0001_0000, 32'h0001_0000, 8'd1};
        stim[14] = '{mduPkg::opMultu, 32'h8000_0001, 32'h0000_0002, 8'd1};
        stim[15] = '{mduPkg::opMult,  32'hffff_ffff, 32'h0000_0005, 8'd1};
        stim[16] = '{mduPkg::opMultu, 32'h0000_0000, 32'hdead_beef, 8'd1};
        stim[17] = '{mduPkg::opMult,  32'h7fff_ffff, 32'h7fff_ffff, 8'd1};
        stim[18] = '{mduPkg::opMult,  32'h8000_0000, 32'h8000_0000, 8'd4};
        // Multiply lands in the hi cycle of the granted divide and gets parked.
        stim[19] = '{mduPkg::opDiv,   32'hffff_ff00, 32'h0000_0013, 8'(33 - `MDU_MUL_CYCLE)};
        stim[20] = '{mduPkg::opMultu, 32'hcafe_f00d, 32'h0000_0101, 8'd1};
        for (int i = NumFixed; i < NumEntries; i++) begin
            r = nextRand();
            stim[i].op  = mduPkg::mduOp'(r[17:16]);
            stim[i].a   = nextRand();
            stim[i].b   = nextRand() >> r[4:0];   // Small divisors give big quotients.
            stim[i].gap = 8'd1 + 8'(r[9:8]);
        end
    endtask

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount == TimeoutCycles)
            failNow($sformatf("timeout: results did not drain after %0d cycles", cycleCount));
    end

    // Every write must be pending, and a hi is followed at once by its lo.
    always @(negedge clk) begin
        if (!rst) begin
            if (wbEn) begin
                if (!(expIssued[wbDst] && !expDone[wbDst]))
                    failNow($sformatf("destination %0d written at %0t but not pending",
                                      wbDst, $time));
                if (prevHi)
                    checkDst("wbDst", wbDst, expPair[prevDst]);
                else if (!expIsHi[wbDst])
                    failNow($sformatf("lo write to %0d at %0t came without its hi", wbDst, $time));
                checkWord("wbData", wbData, expWord[wbDst]);
                checkRob("wbRob", wbRob, expRob[wbDst]);
                if (expIsHi[wbDst] && wbDst == TimedDst)
                    checkLatency("multiply hi latency", cycleCount - timedIssue,
                                 `MDU_MUL_CYCLE + 1);
                expDone[wbDst] = 1'b1;
                writtenCount++;
                prevHi = expIsHi[wbDst];
                prevDst = wbDst;
            end else begin
                if (prevHi)
                    failNow($sformatf("hi write to %0d was not followed by its lo", prevDst));
                prevHi = 1'b0;
            end
        end else if (cycleCount > 0) begin
            checkBit("wbEn", wbEn, 1'b0);         // Quiet once reset has been sampled.
            checkBit("divBusy", divBusy, 1'b0);
        end
    end

    initial begin
        logic [2*W-1:0] res;
        mduPkg::prfNum  hd;
        mduPkg::prfNum  ld;
        int             spacing;
        issueValid = 1'b0;
        issueOp    = mduPkg::opMult;
        srcA       = '0;
        srcB       = '0;
        dstHi      = '0;
        dstLo      = '0;
        robHi      = '0;
        robLo      = '0;
        for (int d = 0; d < NumRegs; d++) begin
            expIssued[d] = 1'b0;
            expDone[d]   = 1'b0;
            expIsHi[d]   = 1'b0;
        end
        loadTable();

        @(posedge clk);
        while (rst) @(posedge clk);
        #1;
        for (int i = 0; i < NumEntries; i++) begin
            if (stim[i].op == mduPkg::opDiv || stim[i].op == mduPkg::opDivu) begin
                while (divBusy) begin
                    @(posedge clk);
                    #1;
                end
            end
            res = expectedResult(stim[i].op, stim[i].a, stim[i].b);
            hd = mduPkg::prfNum'(2 * i);
            ld = mduPkg::prfNum'(2 * i + 1);
            expWord[hd] = res[2*W-1:W];
            expWord[ld] = res[W-1:0];
            expRob[hd] = mduPkg::robId'(2 * i);
            expRob[ld] = mduPkg::robId'(2 * i + 1);
            expPair[hd] = ld;
            expPair[ld] = hd;
            expIsHi[hd] = 1'b1;
            expIssued[hd] = 1'b1;
            expIssued[ld] = 1'b1;
            if (i == 0)
                timedIssue = cycleCount + 1;   // Edge that samples the issue.
            issueValid = 1'b1;
            issueOp = stim[i].op;
            srcA = stim[i].a;
            srcB = stim[i].b;
            dstHi = hd;
            dstLo = ld;
            robHi = expRob[hd];
            robLo = expRob[ld];
            @(posedge clk);
            #1;
            issueValid = 1'b0;
            if (stim[i].op == mduPkg::opDiv || stim[i].op == mduPkg::opDivu)
                checkBit("divBusy", divBusy, 1'b1);   // Busy from the cycle after issue.
            spacing = (stim[i].gap < 8'd1) ? 1 : int'(stim[i].gap);
            repeat (spacing) begin
                @(posedge clk);
                #1;
            end
        end

        while (writtenCount != 2 * NumEntries) @(posedge clk);
        @(posedge clk);
        $display("all tests passed");
        $finish;
    end
endmodule

/* flist.f */
+incdir+common
common/mduPkg.sv
mdu/mulPipe.sv
mdu/divUnit.sv
mdu/mduWriteback.sv
mdu/mduTop.sv
dv/tbClock.sv
dv/mduTb.sv

/* run.sh */
#!/bin/sh
# Build and run the MDU testbench with Verilator.
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module mduTb -o mduSim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/mduSim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^all tests passed$" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1
